// File: bench/cache_tb.sv
// cache testbench applying a table of CPU requests against a reference cache and memory model
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_tb
    import cache_geom_pkg::*, cache_txn_pkg::*;
();

    localparam int MEM_WORDS   = 1 << `ADDR_W;
    localparam int MAX_ROWS    = 40;
    localparam int ACK_LIMIT   = 600;  // cycles for one cpu_ack edge behind a full queue
    localparam int DRAIN_LIMIT = 3000;

    typedef struct packed {
        cache_op_t op;
        addr_t     addr;
        data_t     wdata;
        logic      slow;      // sink holds rsp_ack back for this row
        logic      exp_hit;
        data_t     exp_rdata; // reads only
    } row_t;

    logic      clk       = 1'b0;
    logic      rst_n     = 1'b0;
    logic      cpu_req   = 1'b0;
    logic      cpu_ack;
    cache_op_t cpu_op    = op_read;
    addr_t     cpu_addr  = '0;
    data_t     cpu_wdata = '0;
    logic      rsp_req;
    logic      rsp_ack   = 1'b0;
    data_t     rsp_rdata;
    logic      rsp_hit;
    logic      mem_req;
    logic      mem_ack   = 1'b0;
    logic      mem_we;
    addr_t     mem_addr;
    data_t     mem_wdata;
    data_t     mem_rdata = '0;

    row_t   rows [MAX_ROWS];
    int     n_rows    = 0;
    int     rsp_count = 0;
    int     errors    = 0;
    int     timeouts  = 0;
    integer seed;

    data_t  mem     [MEM_WORDS]; // memory behind the DUT
    data_t  ref_mem [MEM_WORDS]; // memory of the reference model

    // reference cache
    logic   m_valid [`CACHE_SETS][`CACHE_WAYS];
    tag_t   m_tag   [`CACHE_SETS][`CACHE_WAYS];
    data_t  m_data  [`CACHE_SETS][`CACHE_WAYS];
    logic   m_root  [`CACHE_SETS];
    logic   m_left  [`CACHE_SETS];
    logic   m_right [`CACHE_SETS];

    logic   mem_busy  = 1'b0;
    int     mem_delay = 0;
    logic   sink_busy = 1'b0;
    int     sink_wait = 0;

    cache_top DUT (.*);

    always #4 clk = ~clk;

    function automatic data_t init_word(input addr_t a);
        return {~a, a} ^ 32'h3c5a_0f96; // every address bit shows up in the word
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_hit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("run finished: %0d mismatches, %0d timeouts, %0d of %0d responses",
                 errors, timeouts, rsp_count, n_rows);
        if (errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        timeouts++;
    endtask

    task automatic add_row(input cache_op_t op, input addr_t addr, input data_t wdata,
                           input logic slow);
        rows[n_rows] = '{op: op, addr: addr, wdata: wdata, slow: slow,
                         exp_hit: 1'b0, exp_rdata: '0};
        n_rows++;
    endtask

    // pseudo-LRU tree bits point away from the way just used
    task automatic model_touch(input index_t set_i, input int way);
        m_root[set_i] = (way < 2);
        if (way < 2) m_left[set_i] = (way == 0);
        else m_right[set_i] = (way == 2);
    endtask

    function automatic int model_victim(input index_t set_i);
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (!m_valid[set_i][w]) return w; // lowest empty way first
        end
        if (m_root[set_i]) return m_right[set_i] ? 3 : 2;
        return m_left[set_i] ? 1 : 0;
    endfunction

    // runs one row through the reference model and fills its expected columns
    task automatic model_step(input int i);
        index_t set_i;
        tag_t   tag;
        int     way;
        set_i = index_t'(rows[i].addr);
        tag   = tag_t'(rows[i].addr >> $bits(index_t));
        way   = -1;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (m_valid[set_i][w] && m_tag[set_i][w] == tag) way = w;
        end
        rows[i].exp_hit = (way >= 0);
        if (rows[i].op == op_write) begin
            ref_mem[rows[i].addr] = rows[i].wdata; // write-through without allocate
            if (way >= 0) begin
                m_data[set_i][way] = rows[i].wdata;
                model_touch(set_i, way);
            end
        end else begin
            if (way < 0) begin
                way = model_victim(set_i);
                m_valid[set_i][way] = 1'b1;
                m_tag[set_i][way]   = tag;
                m_data[set_i][way]  = ref_mem[rows[i].addr];
            end
            rows[i].exp_rdata = m_data[set_i][way];
            model_touch(set_i, way);
        end
    endtask

    task automatic build_table();
        add_row(op_read,  16'h0010, '0, 1'b0); // cold miss then hit
        add_row(op_read,  16'h0010, '0, 1'b0);
        add_row(op_read,  16'h1237, '0, 1'b0);
        add_row(op_read,  16'h1237, '0, 1'b0);
        add_row(op_read,  16'h0013, '0, 1'b0); // fill all ways of set 3
        add_row(op_read,  16'h0023, '0, 1'b0);
        add_row(op_read,  16'h0033, '0, 1'b0);
        add_row(op_read,  16'h0043, '0, 1'b0);
        add_row(op_read,  16'h0033, '0, 1'b0); // touch ways 2, 0, 3
        add_row(op_read,  16'h0013, '0, 1'b0);
        add_row(op_read,  16'h0043, '0, 1'b0);
        add_row(op_read,  16'h0053, '0, 1'b0); // fifth tag evicts way 1
        add_row(op_read,  16'h0013, '0, 1'b0);
        add_row(op_read,  16'h0033, '0, 1'b0);
        add_row(op_read,  16'h0043, '0, 1'b0);
        add_row(op_read,  16'h0023, '0, 1'b0); // evicted one misses
        add_row(op_write, 16'h0013, 32'hdead_beef, 1'b0); // write hit
        add_row(op_read,  16'h0013, '0, 1'b0);
        add_row(op_write, 16'h0777, 32'h1234_5678, 1'b0); // write miss without allocate
        add_row(op_read,  16'h0777, '0, 1'b0);
        add_row(op_read,  16'h0777, '0, 1'b0);
        add_row(op_write, 16'h0010, 32'ha5a5_0010, 1'b1); // burst behind a slow sink
        add_row(op_read,  16'h0010, '0, 1'b1);
        add_row(op_read,  16'h0ab5, '0, 1'b1);
        add_row(op_write, 16'h0ab5, 32'h0f0f_7777, 1'b1);
        add_row(op_read,  16'h0ab5, '0, 1'b1);
        add_row(op_read,  16'h1237, '0, 1'b1);
        add_row(op_write, 16'h2000, 32'h8000_0001, 1'b1);
        add_row(op_read,  16'h2000, '0, 1'b1);
        add_row(op_read,  16'h0053, '0, 1'b1);
    endtask

    task automatic wait_cpu_ack(input logic level);
        int n;
        n = 0;
        while (cpu_ack !== level && n < ACK_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (cpu_ack !== level) report_timeout($sformatf("cpu_ack stuck, waiting for %b", level));
    endtask

    task automatic send_request(input int i);
        cpu_op    <= rows[i].op;
        cpu_addr  <= rows[i].addr;
        cpu_wdata <= rows[i].wdata;
        cpu_req   <= 1'b1;
        wait_cpu_ack(1'b1);
        if (timeouts == 0) begin
            cpu_req <= 1'b0;
            wait_cpu_ack(1'b0);
        end
    endtask

    task automatic wait_responses();
        int n;
        n = 0;
        while (rsp_count < n_rows && n < DRAIN_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rsp_count < n_rows) report_timeout("not every request got a response");
    endtask

    // memory model acking after 1 to 4 cycles with read data valid alongside
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_ack  <= 1'b0;
            mem_busy <= 1'b0;
        end else if (mem_ack) begin
            if (!mem_req) mem_ack <= 1'b0;
        end else if (mem_req && !mem_busy) begin
            mem_busy  <= 1'b1;
            mem_delay <= 1 + ($unsigned($random(seed)) % 4);
        end else if (mem_busy) begin
            if (mem_delay > 1) begin
                mem_delay <= mem_delay - 1;
            end else begin
                mem_busy <= 1'b0;
                mem_ack  <= 1'b1;
                if (mem_we) mem[mem_addr] <= mem_wdata;
                else mem_rdata <= mem[mem_addr];
            end
        end
    end

    // response sink checking each response against the next row in order
    always @(posedge clk) begin
        if (!rst_n) begin
            rsp_ack   <= 1'b0;
            sink_busy <= 1'b0;
            rsp_count <= 0;
        end else if (rsp_ack) begin
            if (!rsp_req) rsp_ack <= 1'b0;
        end else if (rsp_req && !sink_busy) begin
            if (rsp_count >= n_rows) begin
                $display("error at %0t: response arrived with no request left", $time);
                errors++;
                sink_wait <= 0;
            end else begin
                check_hit($sformatf("rsp_hit row %0d", rsp_count), rsp_hit,
                          rows[rsp_count].exp_hit);
                if (rows[rsp_count].op == op_read) begin
                    check_data($sformatf("rsp_rdata row %0d", rsp_count), rsp_rdata,
                               rows[rsp_count].exp_rdata);
                end
                sink_wait <= rows[rsp_count].slow ? 12 : ($unsigned($random(seed)) % 3);
            end
            rsp_count <= rsp_count + 1;
            sink_busy <= 1'b1;
        end else if (sink_busy) begin
            if (sink_wait > 0) begin
                sink_wait <= sink_wait - 1;
            end else begin
                sink_busy <= 1'b0;
                rsp_ack   <= 1'b1;
            end
        end
    end

    initial begin
        seed = 32;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a]     <= init_word(addr_t'(a));
            ref_mem[a] = init_word(addr_t'(a));
        end
        for (int s = 0; s < `CACHE_SETS; s++) begin
            m_root[s]  = 1'b0;
            m_left[s]  = 1'b0;
            m_right[s] = 1'b0;
            for (int w = 0; w < `CACHE_WAYS; w++) m_valid[s][w] = 1'b0;
        end
        build_table();
        for (int i = 0; i < n_rows; i++) model_step(i);

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < n_rows && timeouts == 0; i++) begin
            send_request(i);
        end
        if (timeouts == 0) begin
            wait_responses();
        end

        // memory contents against the model
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (mem[a] !== ref_mem[a]) check_data($sformatf("mem[%h]", a), mem[a], ref_mem[a]);
        end
        finish_run();
    end

endmodule

// File: flist.f
+incdir+src
src/cache_geom_pkg.sv
src/cache_txn_pkg.sv
src/cache_req_if.sv
src/req_intake.sv
src/req_queue.sv
src/plru_tree.sv
src/cache_ctrl.sv
src/cache_top.sv
bench/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module cache_tb -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src/cache_ctrl.sv
// cache controller: tag and data arrays, hit check, read miss fill and write-through
`timescale 1ns/100ps

`include "cache_settings.svh"

module cache_ctrl
    import cache_geom_pkg::*, cache_txn_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    cache_req_if.dst req,
    output logic     rsp_req,
    input  logic     rsp_ack,
    output data_t    rsp_rdata,
    output logic     rsp_hit,
    output logic     mem_req,
    input  logic     mem_ack,
    output logic     mem_we,
    output addr_t    mem_addr,
    output data_t    mem_wdata,
    input  data_t    mem_rdata
);

    typedef enum logic [1:0] {st_idle, st_lookup, st_mem_access, st_respond} state_t;

    state_t     state;
    logic       req_ack;
    logic       rsp_done; // rsp_ack seen, waiting for it to fall
    logic       hit_q;
    data_t      rdata_q;
    cache_req_t cur_q;
    way_t       fill_way_q;

    way_mask_t  valid    [`CACHE_SETS];
    tag_t       tag_arr  [`CACHE_SETS][`CACHE_WAYS];
    data_t      data_arr [`CACHE_SETS][`CACHE_WAYS];

    index_t     cur_index;
    tag_t       cur_tag;
    way_mask_t  hit_mask;
    logic       hit;
    way_t       hit_way;
    logic       has_invalid;
    way_t       invalid_way;
    way_t       victim;
    logic       start;
    logic       fill_en;
    logic       touch;
    way_t       touch_way;

    assign cur_index = index_t'(cur_q.addr);
    assign cur_tag   = tag_t'(cur_q.addr >> $bits(index_t));

    // tag compare and lowest invalid way
    always_comb begin
        hit_way     = '0;
        invalid_way = '0;
        has_invalid = 1'b0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            hit_mask[w] = valid[cur_index][w] && (tag_arr[cur_index][w] == cur_tag);
        end
        for (int w = `CACHE_WAYS - 1; w >= 0; w--) begin
            if (hit_mask[w]) hit_way = way_t'(w);
            if (!valid[cur_index][w]) begin
                invalid_way = way_t'(w); // lowest wins
                has_invalid = 1'b1;
            end
        end
    end

    assign hit     = |hit_mask;
    assign start   = (state == st_idle) && req.req && !req_ack;
    assign fill_en = (state == st_mem_access) && mem_req && mem_ack && (cur_q.op == op_read);

    // touch on any hit, and on the fill of a read miss
    assign touch     = ((state == st_lookup) && hit) || fill_en;
    assign touch_way = (state == st_lookup) ? hit_way : fill_way_q;

    plru_tree u_plru (
        .clk         (clk),
        .rst_n       (rst_n),
        .touch       (touch),
        .touch_index (cur_index),
        .touch_way   (touch_way),
        .look_index  (cur_index),
        .victim      (victim)
    );

    // request payload, arrays and read data
    always_ff @(posedge clk) begin
        if (start) begin
            cur_q <= '{op: req.op, addr: req.addr, wdata: req.wdata};
        end
        if (state == st_lookup) begin
            fill_way_q <= has_invalid ? invalid_way : victim;
            if (hit && cur_q.op == op_write) begin
                data_arr[cur_index][hit_way] <= cur_q.wdata; // memory gets it too
            end else if (hit) begin
                rdata_q <= data_arr[cur_index][hit_way];
            end
        end
        if (fill_en) begin
            tag_arr[cur_index][fill_way_q]  <= cur_tag;
            data_arr[cur_index][fill_way_q] <= mem_rdata;
            rdata_q                         <= mem_rdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill_en) begin
            valid[cur_index][fill_way_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            req_ack  <= 1'b0;
            rsp_req  <= 1'b0;
            rsp_done <= 1'b0;
            mem_req  <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            if (start) begin
                req_ack <= 1'b1;
            end else if (req_ack && !req.req) begin
                req_ack <= 1'b0;
            end
            case (state)
                st_idle: if (start) state <= st_lookup;
                st_lookup: begin
                    hit_q <= hit;
                    if (cur_q.op == op_write || !hit) begin
                        mem_req <= 1'b1;
                        state   <= st_mem_access;
                    end else begin
                        state <= st_respond;
                    end
                end
                st_mem_access: begin
                    if (mem_req && mem_ack) begin
                        mem_req <= 1'b0;
                    end else if (!mem_req && !mem_ack) begin
                        state <= st_respond;
                    end
                end
                st_respond: begin
                    if (!rsp_req && !rsp_done) begin
                        rsp_req <= 1'b1; // two cycles after ack on a hit
                    end else if (rsp_req && rsp_ack) begin
                        rsp_req  <= 1'b0;
                        rsp_done <= 1'b1;
                    end else if (rsp_done && !rsp_ack) begin
                        rsp_done <= 1'b0;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    assign req.ack   = req_ack;
    assign rsp_rdata = rdata_q;
    assign rsp_hit   = hit_q;
    assign mem_we    = (cur_q.op == op_write);
    assign mem_addr  = cur_q.addr;
    assign mem_wdata = cur_q.wdata;

    // fills only go to a way that missed, so a tag never sits twice in a set
    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_lookup) |-> $onehot0(hit_mask));

endmodule

// File: src/cache_geom_pkg.sv
// cache geometry package: storage types for tags, set index, ways and replacement bits
package cache_geom_pkg;

`include "cache_settings.svh"

    // set index, low address bits
    typedef logic [$clog2(`CACHE_SETS)-1:0] index_t;

    // tag, the address bits above the index
    typedef logic [`ADDR_W-$clog2(`CACHE_SETS)-1:0] tag_t;

    // way number inside a set
    typedef logic [$clog2(`CACHE_WAYS)-1:0] way_t;

    typedef logic [`CACHE_WAYS-1:0] way_mask_t; // one bit per way

    // tree pseudo-LRU state of one set
    // root 1 means the left pair was used last, so the victim is on the right
    typedef struct packed {
        logic root;
        logic left;  // 1 after way 0, 0 after way 1
        logic right; // 1 after way 2, 0 after way 3
    } plru_bits_t;

endpackage

// File: src/cache_req_if.sv
// request interface: four-phase req/ack handshake carrying one cache request
`timescale 1ns/100ps

interface cache_req_if
    import cache_txn_pkg::*;
();

    logic      req;   // held until ack is seen
    logic      ack;   // held until req falls
    cache_op_t op;
    addr_t     addr;
    data_t     wdata;

    // producer side, payload stable while req is high
    modport src (
        output req,
        output op,
        output addr,
        output wdata,
        input  ack
    );

    // consumer side
    modport dst (
        input  req,
        input  op,
        input  addr,
        input  wdata,
        output ack
    );

endinterface

// File: src/cache_settings.svh
// cache settings: geometry of the 4-way cache and depth of the request queue
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// associativity, the pseudo-LRU tree only covers 4
`define CACHE_WAYS 4

// number of sets, one word per line
`define CACHE_SETS 16

// word address width on the CPU and memory ports
`define ADDR_W 16

// data word width
`define DATA_W 32

// entries in the request FIFO between intake and controller
`define QUEUE_DEPTH 4

`endif

// File: src/cache_top.sv
// cache top level: CPU intake, request queue and cache controller on plain ports
`timescale 1ns/100ps

module cache_top
    import cache_txn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_req,
    output logic      cpu_ack,
    input  cache_op_t cpu_op,
    input  addr_t     cpu_addr,
    input  data_t     cpu_wdata,
    output logic      rsp_req,
    input  logic      rsp_ack,
    output data_t     rsp_rdata,
    output logic      rsp_hit,
    output logic      mem_req,
    input  logic      mem_ack,
    output logic      mem_we,
    output addr_t     mem_addr,
    output data_t     mem_wdata,
    input  data_t     mem_rdata
);

    cache_req_if in_if ();  // intake to queue
    cache_req_if out_if (); // queue to controller

    req_intake u_intake (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_req   (cpu_req),
        .cpu_ack   (cpu_ack),
        .cpu_op    (cpu_op),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .q         (in_if.src)
    );

    req_queue u_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (in_if.dst),
        .pop   (out_if.src)
    );

    cache_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (out_if.dst),
        .rsp_req   (rsp_req),
        .rsp_ack   (rsp_ack),
        .rsp_rdata (rsp_rdata),
        .rsp_hit   (rsp_hit),
        .mem_req   (mem_req),
        .mem_ack   (mem_ack),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

endmodule

// File: src/cache_txn_pkg.sv
// cache transaction package: opcode, address, data and the queued request record
package cache_txn_pkg;

`include "cache_settings.svh"

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_t;

    typedef logic [`ADDR_W-1:0] addr_t; // word address

    typedef logic [`DATA_W-1:0] data_t;

    // one CPU request as it sits in the queue
    // wdata is don't care for reads
    typedef struct packed {
        cache_op_t op;
        addr_t     addr;
        data_t     wdata;
    } cache_req_t;

endpackage

// File: src/plru_tree.sv
// tree pseudo-LRU: three bits per set, updated on access, victim way read per set
`timescale 1ns/100ps

`include "cache_settings.svh"

module plru_tree
    import cache_geom_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   touch,
    input  index_t touch_index,
    input  way_t   touch_way,
    input  index_t look_index,
    output way_t   victim
);

    plru_bits_t bits [`CACHE_SETS];
    plru_bits_t look_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                bits[s] <= '0;
            end
        end else if (touch) begin
            // point the tree away from the way just used
            case (touch_way)
                2'd0: begin
                    bits[touch_index].root <= 1'b1;
                    bits[touch_index].left <= 1'b1;
                end
                2'd1: begin
                    bits[touch_index].root <= 1'b1;
                    bits[touch_index].left <= 1'b0;
                end
                2'd2: begin
                    bits[touch_index].root  <= 1'b0;
                    bits[touch_index].right <= 1'b1;
                end
                default: begin
                    bits[touch_index].root  <= 1'b0;
                    bits[touch_index].right <= 1'b0;
                end
            endcase
        end
    end

    assign look_bits = bits[look_index];

    always_comb begin
        if (!look_bits.root) begin
            victim = look_bits.left ? 2'd1 : 2'd0; // left pair
        end else begin
            victim = look_bits.right ? 2'd3 : 2'd2; // right pair
        end
    end

endmodule

// File: src/req_intake.sv
// request intake: captures a CPU request and forwards it over the internal handshake
`timescale 1ns/100ps

module req_intake
    import cache_txn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cpu_req,
    output logic      cpu_ack,
    input  cache_op_t cpu_op,
    input  addr_t     cpu_addr,
    input  data_t     cpu_wdata,
    cache_req_if.src  q
);

    typedef enum logic {cpu_idle, cpu_acked} cpu_state_t;
    typedef enum logic [1:0] {fwd_idle, fwd_req, fwd_drain} fwd_state_t;

    cpu_state_t cpu_state;
    fwd_state_t fwd_state;
    cache_req_t hold_q; // the one buffered request
    logic       capture;

    // holding register is empty only while the forward side is idle
    assign capture = cpu_req && (cpu_state == cpu_idle) && (fwd_state == fwd_idle);

    always_ff @(posedge clk) begin
        if (capture) begin
            hold_q <= '{op: cpu_op, addr: cpu_addr, wdata: cpu_wdata};
        end
    end

    // CPU side handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_state <= cpu_idle;
        end else begin
            case (cpu_state)
                cpu_idle:  if (capture) cpu_state <= cpu_acked;
                cpu_acked: if (!cpu_req) cpu_state <= cpu_idle; // ack falls a cycle later
                default:   cpu_state <= cpu_idle;
            endcase
        end
    end

    // forward handshake towards the queue
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fwd_state <= fwd_idle;
        end else begin
            case (fwd_state)
                fwd_idle:  if (capture) fwd_state <= fwd_req;
                fwd_req:   if (q.ack) fwd_state <= fwd_drain;
                fwd_drain: if (!q.ack) fwd_state <= fwd_idle; // register free again
                default:   fwd_state <= fwd_idle;
            endcase
        end
    end

    assign cpu_ack = (cpu_state == cpu_acked);

    assign q.req   = (fwd_state == fwd_req);
    assign q.op    = hold_q.op;
    assign q.addr  = hold_q.addr;
    assign q.wdata = hold_q.wdata;

    // req stays up with the same payload until the queue acks
    a_fwd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (q.req && !q.ack) |=> (q.req && $stable({q.op, q.addr, q.wdata})));

endmodule

// File: src/req_queue.sv
// request queue holding cache requests in a circular FIFO with four-phase ports on both sides
`timescale 1ns/100ps

`include "cache_settings.svh"

module req_queue
    import cache_txn_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    cache_req_if.dst push,
    cache_req_if.src pop
);

    typedef logic [$clog2(`QUEUE_DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(`QUEUE_DEPTH+1)-1:0] cnt_t;

    typedef enum logic {push_idle, push_acked} push_state_t;
    typedef enum logic [1:0] {pop_idle, pop_req, pop_drain} pop_state_t;

    cache_req_t  fifo [`QUEUE_DEPTH];
    ptr_t        wr_ptr;
    ptr_t        rd_ptr;
    cnt_t        count;
    push_state_t push_state;
    pop_state_t  pop_state;
    logic        full;
    logic        wr_en;
    logic        rd_en;

    assign full  = (count == cnt_t'(`QUEUE_DEPTH));
    assign wr_en = (push_state == push_idle) && push.req && !full; // ack rises with the write
    assign rd_en = (pop_state == pop_req) && pop.ack;              // pop on the controller's ack

    always_ff @(posedge clk) begin
        if (wr_en) begin
            fifo[wr_ptr] <= '{op: push.op, addr: push.addr, wdata: push.wdata};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_t'(`QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_t'(`QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // write side handshake with ack withheld while full
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            push_state <= push_idle;
        end else begin
            case (push_state)
                push_idle:  if (wr_en) push_state <= push_acked;
                push_acked: if (!push.req) push_state <= push_idle;
                default:    push_state <= push_idle;
            endcase
        end
    end

    // read side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_state <= pop_idle;
        end else begin
            case (pop_state)
                pop_idle:  if (count != '0) pop_state <= pop_req;
                pop_req:   if (pop.ack) pop_state <= pop_drain;
                pop_drain: if (!pop.ack) pop_state <= pop_idle;
                default:   pop_state <= pop_idle;
            endcase
        end
    end

    assign push.ack  = (push_state == push_acked);

    assign pop.req   = (pop_state == pop_req);
    assign pop.op    = fifo[rd_ptr].op; // head entry
    assign pop.addr  = fifo[rd_ptr].addr;
    assign pop.wdata = fifo[rd_ptr].wdata;

    // a write into a full FIFO would push the count past the depth
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cnt_t'(`QUEUE_DEPTH));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd_en |-> (count != '0));

endmodule
